// ==== common/pipe_ctrl_pkg.sv ====
`default_nettype none

package pipe_ctrl_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int FUNCT3_W = 3;
    localparam int OPCODE_W = 7;
    localparam int NUM_STAGES = 5;

    // stage bit positions with fetch in the msb
    localparam int STG_IF = 4;
    localparam int STG_DE = 3;
    localparam int STG_EXE = 2;
    localparam int STG_MEM = 1;
    localparam int STG_WB = 0;

    typedef enum logic [OPCODE_W-1:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops_t;

    // also serves as the comparator operation
    typedef enum logic [FUNCT3_W-1:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [FUNCT3_W-1:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [FUNCT3_W-1:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef enum logic {
        am1_rs1_out = 1'b0,
        am1_pc_out  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        am2_i_imm   = 3'b000,
        am2_u_imm   = 3'b001,
        am2_b_imm   = 3'b010,
        am2_s_imm   = 3'b011,
        am2_j_imm   = 3'b100,
        am2_rs2_out = 3'b101
    } alumux2_sel_t;

    typedef enum logic {
        cmp_rs2_out = 1'b0,
        cmp_i_imm   = 1'b1
    } cmpmux_sel_t;

    typedef enum logic {
        mar_pc_out  = 1'b0,
        mar_alu_out = 1'b1
    } marmux_sel_t;

    typedef enum logic [3:0] {
        rf_alu_out  = 4'd0,
        rf_br_en    = 4'd1,
        rf_u_imm    = 4'd2,
        rf_lw       = 4'd3,
        rf_pc_plus4 = 4'd4,
        rf_lb       = 4'd5,
        rf_lbu      = 4'd6,
        rf_lh       = 4'd7,
        rf_lhu      = 4'd8
    } regfilemux_sel_t;

    typedef enum logic [1:0] {
        pcm_pc_plus4 = 2'b00,
        pcm_alu_out  = 2'b01,
        pcm_alu_mod2 = 2'b10
    } pcmux_sel_t;

    // fields of the instruction held in fetch/decode
    typedef struct packed {
        opcode_t               opcode;
        logic [FUNCT3_W-1:0]   funct3;
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rd_addr;
    } instr_fields_t;

    typedef struct packed {
        alumux1_sel_t   alumux1_sel;
        alumux2_sel_t   alumux2_sel;
        cmpmux_sel_t    cmp_sel;
        alu_ops_t       aluop;
        branch_funct3_t cmpop;
    } exe_ctrl_t;

    typedef struct packed {
        logic          mem_read;
        logic          mem_write;
        load_funct3_t  load_funct3;
        store_funct3_t store_funct3;
        marmux_sel_t   mar_sel;
    } mem_ctrl_t;

    typedef struct packed {
        logic                  ld_reg;
        regfilemux_sel_t       regfilemux_sel;
        logic [REG_ADDR_W-1:0] rd_sel;
    } wb_ctrl_t;

    typedef struct packed {
        exe_ctrl_t exe;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
    } ctrl_word_t;

    typedef logic [NUM_STAGES-1:0] stage_flags_t;

    // bubble with no memory access and no register write
    localparam ctrl_word_t CTRL_WORD_DEFAULT = '{
        exe: '{alumux1_sel: am1_rs1_out, alumux2_sel: am2_i_imm,
               cmp_sel: cmp_rs2_out, aluop: alu_add, cmpop: beq},
        mem: '{mem_read: 1'b0, mem_write: 1'b0, load_funct3: lb,
               store_funct3: sb, mar_sel: mar_pc_out},
        wb:  '{ld_reg: 1'b0, regfilemux_sel: rf_alu_out, rd_sel: '0}
    };

endpackage : pipe_ctrl_pkg

`default_nettype wire

// ==== decode/arith_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module arith_decoder (
    input  wire logic [pipe_ctrl_pkg::FUNCT3_W-1:0] i_funct3,
    input  wire logic                               i_funct7_b5,
    input  wire logic                               i_is_imm,
    output pipe_ctrl_pkg::exe_ctrl_t                o_exe,
    output pipe_ctrl_pkg::regfilemux_sel_t          o_wb_src
);

    import pipe_ctrl_pkg::*;

    alumux2_sel_t op2_sel;
    cmpmux_sel_t  cmp_src;

    // second operand comes from the immediate or from rs2
    assign op2_sel = i_is_imm ? am2_i_imm : am2_rs2_out;
    assign cmp_src = i_is_imm ? cmp_i_imm : cmp_rs2_out;

    always_comb begin
        o_exe.alumux1_sel = am1_rs1_out;
        o_exe.alumux2_sel = op2_sel;
        o_exe.cmp_sel = cmp_rs2_out;
        o_exe.aluop = alu_add;
        o_exe.cmpop = beq;
        o_wb_src = rf_alu_out;

        case (i_funct3)
            3'b000: begin
                // sub exists only in register form
                if (!i_is_imm && i_funct7_b5) begin
                    o_exe.aluop = alu_sub;
                end
                else begin
                    o_exe.aluop = alu_add;
                end
            end
            3'b001: begin
                o_exe.aluop = alu_sll;
            end
            3'b010: begin
                // slt takes its result from the comparator
                o_exe.cmpop = blt;
                o_exe.cmp_sel = cmp_src;
                o_wb_src = rf_br_en;
            end
            3'b011: begin
                // sltu
                o_exe.cmpop = bltu;
                o_exe.cmp_sel = cmp_src;
                o_wb_src = rf_br_en;
            end
            3'b100: begin
                o_exe.aluop = alu_xor;
            end
            3'b101: begin
                if (i_funct7_b5) begin
                    o_exe.aluop = alu_sra;
                end
                else begin
                    o_exe.aluop = alu_srl;
                end
            end
            3'b110: begin
                o_exe.aluop = alu_or;
            end
            default: begin
                o_exe.aluop = alu_and;
            end
        endcase
    end

endmodule : arith_decoder

`default_nettype wire

// ==== decode/ctrl_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_decoder (
    input  wire logic                     rst,
    input  wire logic                     i_if_rdy,
    input  pipe_ctrl_pkg::instr_fields_t  i_instr,
    input  wire logic                     i_br_en,
    output pipe_ctrl_pkg::ctrl_word_t     o_ctrl_word,
    output pipe_ctrl_pkg::pcmux_sel_t     o_pcmux_sel
);

    import pipe_ctrl_pkg::*;

    exe_ctrl_t       arith_exe;
    regfilemux_sel_t arith_wb_src;
    logic            is_imm;

    assign is_imm = (i_instr.opcode == op_imm);

    arith_decoder u_arith_decoder (
        .i_funct3    (i_instr.funct3),
        .i_funct7_b5 (i_instr.funct7[5]),
        .i_is_imm    (is_imm),
        .o_exe       (arith_exe),
        .o_wb_src    (arith_wb_src)
    );

    always_comb begin
        o_ctrl_word = CTRL_WORD_DEFAULT;
        o_pcmux_sel = pcm_pc_plus4;

        // bubble while in reset or while fetch has nothing ready
        if (!rst && i_if_rdy) begin
            case (i_instr.opcode)
                op_lui: begin
                    o_ctrl_word.wb.ld_reg = 1'b1;
                    o_ctrl_word.wb.regfilemux_sel = rf_u_imm;
                    o_ctrl_word.wb.rd_sel = i_instr.rd_addr;
                end
                op_auipc: begin
                    o_ctrl_word.exe.alumux1_sel = am1_pc_out;
                    o_ctrl_word.exe.alumux2_sel = am2_u_imm;
                    o_ctrl_word.wb.ld_reg = 1'b1;
                    o_ctrl_word.wb.rd_sel = i_instr.rd_addr;
                end
                op_jal: begin
                    o_ctrl_word.exe.alumux1_sel = am1_pc_out;
                    o_ctrl_word.exe.alumux2_sel = am2_j_imm;
                    o_ctrl_word.wb.ld_reg = 1'b1;
                    o_ctrl_word.wb.regfilemux_sel = rf_pc_plus4;
                    o_ctrl_word.wb.rd_sel = i_instr.rd_addr;
                    o_pcmux_sel = pcm_alu_out;
                end
                op_jalr: begin
                    // rs1 + i_imm is already the default datapath
                    o_ctrl_word.wb.ld_reg = 1'b1;
                    o_ctrl_word.wb.regfilemux_sel = rf_pc_plus4;
                    o_ctrl_word.wb.rd_sel = i_instr.rd_addr;
                    o_pcmux_sel = pcm_alu_mod2;
                end
                op_br: begin
                    case (i_instr.funct3)
                        3'b001: o_ctrl_word.exe.cmpop = bne;
                        3'b100: o_ctrl_word.exe.cmpop = blt;
                        3'b101: o_ctrl_word.exe.cmpop = bge;
                        3'b110: o_ctrl_word.exe.cmpop = bltu;
                        3'b111: o_ctrl_word.exe.cmpop = bgeu;
                        default: o_ctrl_word.exe.cmpop = beq;
                    endcase
                    // a taken branch targets pc + b_imm
                    if (i_br_en) begin
                        o_ctrl_word.exe.alumux1_sel = am1_pc_out;
                        o_ctrl_word.exe.alumux2_sel = am2_b_imm;
                        o_pcmux_sel = pcm_alu_out;
                    end
                end
                op_load: begin
                    o_ctrl_word.mem.mem_read = 1'b1;
                    o_ctrl_word.mem.mar_sel = mar_alu_out;
                    o_ctrl_word.mem.load_funct3 = load_funct3_t'(i_instr.funct3);
                    o_ctrl_word.wb.ld_reg = 1'b1;
                    o_ctrl_word.wb.rd_sel = i_instr.rd_addr;
                    case (i_instr.funct3)
                        3'b000: o_ctrl_word.wb.regfilemux_sel = rf_lb;
                        3'b001: o_ctrl_word.wb.regfilemux_sel = rf_lh;
                        3'b010: o_ctrl_word.wb.regfilemux_sel = rf_lw;
                        3'b100: o_ctrl_word.wb.regfilemux_sel = rf_lbu;
                        3'b101: o_ctrl_word.wb.regfilemux_sel = rf_lhu;
                        default: o_ctrl_word.wb.regfilemux_sel = rf_alu_out;
                    endcase
                end
                op_store: begin
                    o_ctrl_word.exe.alumux2_sel = am2_s_imm;
                    o_ctrl_word.mem.mem_write = 1'b1;
                    o_ctrl_word.mem.mar_sel = mar_alu_out;
                    o_ctrl_word.mem.store_funct3 = store_funct3_t'(i_instr.funct3);
                end
                op_imm, op_reg: begin
                    o_ctrl_word.exe = arith_exe;
                    o_ctrl_word.wb.ld_reg = 1'b1;
                    o_ctrl_word.wb.regfilemux_sel = arith_wb_src;
                    o_ctrl_word.wb.rd_sel = i_instr.rd_addr;
                end
                default: begin
                    o_ctrl_word = CTRL_WORD_DEFAULT;
                end
            endcase
        end
    end

    // memory stage sees at most one request per instruction
    always_comb begin
        a_mem_exclusive: assert (!(o_ctrl_word.mem.mem_read && o_ctrl_word.mem.mem_write))
            else $error("ctrl_decoder: read and write requested together");
    end

endmodule : ctrl_decoder

`default_nettype wire

// ==== hdl/stage_load_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_load_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  pipe_ctrl_pkg::stage_flags_t i_rdy,
    input  pipe_ctrl_pkg::stage_flags_t i_valid,
    output logic                        o_fetch_en,
    output logic                        o_if_de_ld,
    output logic                        o_de_exe_ld,
    output logic                        o_exe_mem_ld,
    output logic                        o_mem_wb_ld
);

    import pipe_ctrl_pkg::*;

    // a stage stalls when it holds a valid instruction but is not done
    logic [STG_DE:STG_WB] stall;
    // hold[k] set when stage k or any later stage stalls
    logic [STG_DE:STG_WB] hold;

    assign stall = i_valid[STG_DE:STG_WB] & ~i_rdy[STG_DE:STG_WB];

    always_comb begin
        hold[STG_WB] = stall[STG_WB];
        for (int k = STG_WB + 1; k <= STG_DE; k++) begin
            hold[k] = hold[k-1] | stall[k];
        end
    end

    // cold start needs a valid instruction in the stage feeding the register
    always_comb begin
        o_if_de_ld   = !rst && !hold[STG_DE];
        o_de_exe_ld  = !rst && !hold[STG_EXE] && i_valid[STG_IF];
        o_exe_mem_ld = !rst && !hold[STG_MEM] && i_valid[STG_DE];
        o_mem_wb_ld  = !rst && !hold[STG_WB] && i_valid[STG_EXE];
    end

    // pc and imem read follow the first pipeline register
    assign o_fetch_en = o_if_de_ld;

    // a stall downstream freezes every register upstream of it
    a_stall_upstream: assert property (@(posedge clk) disable iff (rst)
        (hold[STG_WB] |-> !o_exe_mem_ld) and
        (hold[STG_MEM] |-> !o_de_exe_ld) and
        (hold[STG_EXE] |-> !o_if_de_ld))
        else $error("stage_load_ctrl: upstream load during downstream stall");

    // fetch holds in reset and whenever any later stage stalls
    a_fetch_hold: assert property (@(posedge clk) (rst || (|stall)) |-> !o_fetch_en)
        else $error("stage_load_ctrl: fetch enabled during reset or a stall");

endmodule : stage_load_ctrl

`default_nettype wire

// ==== hdl/mp4_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module mp4_control (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  pipe_ctrl_pkg::instr_fields_t i_instr,
    input  wire logic                   i_br_en,
    input  pipe_ctrl_pkg::stage_flags_t i_rdy,
    input  pipe_ctrl_pkg::stage_flags_t i_valid,
    output pipe_ctrl_pkg::ctrl_word_t   o_ctrl_word,
    output pipe_ctrl_pkg::pcmux_sel_t   o_pcmux_sel,
    output logic                        o_fetch_en,
    output logic                        o_if_de_ld,
    output logic                        o_de_exe_ld,
    output logic                        o_exe_mem_ld,
    output logic                        o_mem_wb_ld
);

    import pipe_ctrl_pkg::*;

    // decode of the instruction waiting in fetch
    ctrl_decoder u_ctrl_decoder (
        .rst         (rst),
        .i_if_rdy    (i_rdy[STG_IF]),
        .i_instr     (i_instr),
        .i_br_en     (i_br_en),
        .o_ctrl_word (o_ctrl_word),
        .o_pcmux_sel (o_pcmux_sel)
    );

    // pipeline register load enables
    stage_load_ctrl u_stage_load_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_rdy        (i_rdy),
        .i_valid      (i_valid),
        .o_fetch_en   (o_fetch_en),
        .o_if_de_ld   (o_if_de_ld),
        .o_de_exe_ld  (o_de_exe_ld),
        .o_exe_mem_ld (o_exe_mem_ld),
        .o_mem_wb_ld  (o_mem_wb_ld)
    );

endmodule : mp4_control

`default_nettype wire

// ==== verification/tb_mp4_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mp4_control;

    import pipe_ctrl_pkg::*;

    typedef enum int {
        t_reset, t_free_flow, t_random_flow, t_wb_stall, t_cold_start,
        t_arith, t_upper_imm, t_jump, t_branch, t_load, t_store, t_fetch_stall
    } test_t;

    logic          clk;
    logic          rst;
    instr_fields_t i_instr;
    logic          i_br_en;
    stage_flags_t  i_rdy;
    stage_flags_t  i_valid;
    ctrl_word_t    o_ctrl_word;
    pcmux_sel_t    o_pcmux_sel;
    logic          o_fetch_en;
    logic          o_if_de_ld;
    logic          o_de_exe_ld;
    logic          o_exe_mem_ld;
    logic          o_mem_wb_ld;

    test_t      test_id = t_reset;
    int         issued = 0;
    int         compared = 0;
    int         checks = 0;
    int         errors = 0;
    int         timeouts = 0;
    ctrl_word_t exp_cw;
    pcmux_sel_t exp_pc;
    logic [4:0] exp_ld;

    opcode_t    all_ops[9] = '{op_lui, op_auipc, op_jal, op_jalr, op_br,
                               op_load, op_store, op_imm, op_reg};
    logic [2:0] br_codes[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [2:0] ld_codes[5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

    mp4_control DUT (
        .clk          (clk),
        .rst          (rst),
        .i_instr      (i_instr),
        .i_br_en      (i_br_en),
        .i_rdy        (i_rdy),
        .i_valid      (i_valid),
        .o_ctrl_word  (o_ctrl_word),
        .o_pcmux_sel  (o_pcmux_sel),
        .o_fetch_en   (o_fetch_en),
        .o_if_de_ld   (o_if_de_ld),
        .o_de_exe_ld  (o_de_exe_ld),
        .o_exe_mem_ld (o_exe_mem_ld),
        .o_mem_wb_ld  (o_mem_wb_ld)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // expected control word and next-pc select for one instruction
    function automatic ctrl_word_t ref_ctrl(input logic rst_v, input logic if_rdy,
                                            input instr_fields_t ins, input logic br,
                                            output pcmux_sel_t pc_sel);
        ctrl_word_t cw;
        logic       is_imm;
        logic       writes_rd;
        cw = CTRL_WORD_DEFAULT;
        pc_sel = pcm_pc_plus4;
        is_imm = (ins.opcode == op_imm);
        writes_rd = 1'b0;
        if (!rst_v && if_rdy) begin
            case (ins.opcode)
                op_lui: begin
                    writes_rd = 1'b1;
                    cw.wb.regfilemux_sel = rf_u_imm;
                end
                op_auipc: begin
                    writes_rd = 1'b1;
                    cw.exe.alumux1_sel = am1_pc_out;
                    cw.exe.alumux2_sel = am2_u_imm;
                end
                op_jal: begin
                    writes_rd = 1'b1;
                    cw.exe.alumux1_sel = am1_pc_out;
                    cw.exe.alumux2_sel = am2_j_imm;
                    cw.wb.regfilemux_sel = rf_pc_plus4;
                    pc_sel = pcm_alu_out;
                end
                op_jalr: begin
                    writes_rd = 1'b1;
                    cw.wb.regfilemux_sel = rf_pc_plus4;
                    pc_sel = pcm_alu_mod2;
                end
                op_br: begin
                    // funct3 010 and 011 are not branches
                    if (ins.funct3 == 3'd2 || ins.funct3 == 3'd3) begin
                        cw.exe.cmpop = beq;
                    end
                    else begin
                        cw.exe.cmpop = branch_funct3_t'(ins.funct3);
                    end
                    if (br) begin
                        cw.exe.alumux1_sel = am1_pc_out;
                        cw.exe.alumux2_sel = am2_b_imm;
                        pc_sel = pcm_alu_out;
                    end
                end
                op_load: begin
                    writes_rd = 1'b1;
                    cw.mem.mem_read = 1'b1;
                    cw.mem.mar_sel = mar_alu_out;
                    cw.mem.load_funct3 = load_funct3_t'(ins.funct3);
                    case (ins.funct3)
                        3'd0: cw.wb.regfilemux_sel = rf_lb;
                        3'd1: cw.wb.regfilemux_sel = rf_lh;
                        3'd2: cw.wb.regfilemux_sel = rf_lw;
                        3'd4: cw.wb.regfilemux_sel = rf_lbu;
                        3'd5: cw.wb.regfilemux_sel = rf_lhu;
                        default: cw.wb.regfilemux_sel = rf_alu_out;
                    endcase
                end
                op_store: begin
                    cw.exe.alumux2_sel = am2_s_imm;
                    cw.mem.mem_write = 1'b1;
                    cw.mem.mar_sel = mar_alu_out;
                    cw.mem.store_funct3 = store_funct3_t'(ins.funct3);
                end
                op_imm, op_reg: begin
                    writes_rd = 1'b1;
                    cw.exe.alumux2_sel = is_imm ? am2_i_imm : am2_rs2_out;
                    case (ins.funct3)
                        3'd0: cw.exe.aluop = (!is_imm && ins.funct7[5]) ? alu_sub : alu_add;
                        3'd1: cw.exe.aluop = alu_sll;
                        3'd2, 3'd3: begin
                            // slt and sltu write the comparator result
                            cw.exe.cmpop = (ins.funct3 == 3'd2) ? blt : bltu;
                            cw.exe.cmp_sel = is_imm ? cmp_i_imm : cmp_rs2_out;
                            cw.wb.regfilemux_sel = rf_br_en;
                        end
                        3'd4: cw.exe.aluop = alu_xor;
                        3'd5: cw.exe.aluop = ins.funct7[5] ? alu_sra : alu_srl;
                        3'd6: cw.exe.aluop = alu_or;
                        default: cw.exe.aluop = alu_and;
                    endcase
                end
                default: begin
                    writes_rd = 1'b0;
                end
            endcase
            if (writes_rd) begin
                cw.wb.ld_reg = 1'b1;
                cw.wb.rd_sel = ins.rd_addr;
            end
        end
        return cw;
    endfunction

    // {fetch, if/de, de/exe, exe/mem, mem/wb}
    function automatic logic [4:0] ref_loads(input logic rst_v, input stage_flags_t rdy,
                                             input stage_flags_t vld);
        logic st_de;
        logic st_exe;
        logic st_mem;
        logic st_wb;
        logic [4:0] ld;
        st_de = vld[STG_DE] && !rdy[STG_DE];
        st_exe = vld[STG_EXE] && !rdy[STG_EXE];
        st_mem = vld[STG_MEM] && !rdy[STG_MEM];
        st_wb = vld[STG_WB] && !rdy[STG_WB];
        ld[0] = !st_wb && vld[STG_EXE];
        ld[1] = !st_wb && !st_mem && vld[STG_DE];
        ld[2] = !st_wb && !st_mem && !st_exe && vld[STG_IF];
        ld[3] = !st_wb && !st_mem && !st_exe && !st_de;
        ld[4] = ld[3];
        return rst_v ? 5'b0 : ld;
    endfunction

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic instr_fields_t make_instr(input opcode_t op, input logic [2:0] f3,
                                                 input logic [6:0] f7, input logic [4:0] rd);
        instr_fields_t ins;
        ins.opcode = op;
        ins.funct3 = f3;
        ins.funct7 = f7;
        ins.rd_addr = rd;
        return ins;
    endfunction

    function automatic instr_fields_t rand_instr(input opcode_t op);
        logic [6:0] f7;
        f7 = (($urandom % 2) != 0) ? 7'h20 : 7'h00;
        return make_instr(op, 3'($urandom), f7, 5'($urandom));
    endfunction

    // one new input set per rising edge
    task automatic drive(input test_t id, input logic rst_v, input instr_fields_t ins,
                         input logic br, input stage_flags_t rdy, input stage_flags_t vld);
        @(posedge clk);
        test_id <= id;
        rst <= rst_v;
        i_instr <= ins;
        i_br_en <= br;
        i_rdy <= rdy;
        i_valid <= vld;
        issued <= issued + 1;
    endtask

    task automatic wait_fetch_en(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (o_fetch_en !== 1'b1 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (o_fetch_en !== 1'b1) begin
            timeouts++;
            $display("Timeout: fetch enable stayed low after reset was released");
        end
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        // the last vector is compared at the next falling edge
        @(negedge clk);
        while (compared != issued && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (compared != issued) begin
            timeouts++;
            $display("Timeout: comparison process did not catch up with the stimulus");
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (issued != compared) begin
            exp_cw = ref_ctrl(rst, i_rdy[STG_IF], i_instr, i_br_en, exp_pc);
            exp_ld = ref_loads(rst, i_rdy, i_valid);
            check_val({test_id.name(), " ctrl_word"}, 64'(exp_cw), 64'(o_ctrl_word));
            check_val({test_id.name(), " pcmux_sel"}, 64'(exp_pc), 64'(o_pcmux_sel));
            check_val({test_id.name(), " loads"}, 64'(exp_ld),
                      64'({o_fetch_en, o_if_de_ld, o_de_exe_ld, o_exe_mem_ld, o_mem_wb_ld}));
            compared <= issued;
        end
    end

    initial begin
        stage_flags_t vld;
        void'($urandom(32'hfd26));
        rst = 1'b1;
        i_instr = '0;
        i_br_en = 1'b0;
        i_rdy = '0;
        i_valid = '0;

        // any traffic during reset gives a bubble
        for (int i = 0; i < 8; i++) begin
            drive(t_reset, 1'b1, rand_instr(all_ops[$urandom % 9]), 1'($urandom),
                  5'($urandom), 5'($urandom));
        end
        drive(t_free_flow, 1'b0, rand_instr(op_reg), 1'b0, '1, '1);
        wait_fetch_en(10);
        for (int i = 0; i < 40; i++) begin
            drive(t_random_flow, 1'b0, rand_instr(all_ops[$urandom % 9]), 1'($urandom),
                  5'($urandom), 5'($urandom));
        end
        drive(t_wb_stall, 1'b0, rand_instr(op_imm), 1'b0, 5'b11110, 5'b11111);

        // valid fills in from fetch toward writeback
        vld = '0;
        for (int i = 0; i <= NUM_STAGES; i++) begin
            drive(t_cold_start, 1'b0, rand_instr(op_reg), 1'b0, '1, vld);
            vld = {1'b1, vld[NUM_STAGES-1:1]};
        end

        for (int i = 0; i < 60; i++) begin
            drive(t_arith, 1'b0, rand_instr((($urandom % 2) != 0) ? op_imm : op_reg),
                  1'($urandom), '1, '1);
        end
        for (int i = 0; i < 8; i++) begin
            drive(t_arith, 1'b0, make_instr(op_reg, 3'(i), 7'h20, 5'($urandom)), 1'b0, '1, '1);
            drive(t_arith, 1'b0, make_instr(op_imm, 3'(i), 7'h20, 5'($urandom)), 1'b0, '1, '1);
        end

        for (int b = 0; b < 2; b++) begin
            drive(t_upper_imm, 1'b0, rand_instr(op_lui), 1'(b), '1, '1);
            drive(t_upper_imm, 1'b0, rand_instr(op_auipc), 1'(b), '1, '1);
            drive(t_jump, 1'b0, rand_instr(op_jal), 1'(b), '1, '1);
            drive(t_jump, 1'b0, rand_instr(op_jalr), 1'(b), '1, '1);
            for (int k = 0; k < 6; k++) begin
                drive(t_branch, 1'b0, make_instr(op_br, br_codes[k], 7'($urandom),
                      5'($urandom)), 1'(b), '1, '1);
            end
        end

        for (int k = 0; k < 5; k++) begin
            drive(t_load, 1'b0, make_instr(op_load, ld_codes[k], 7'($urandom),
                  5'($urandom)), 1'($urandom), '1, '1);
        end
        for (int k = 0; k < 3; k++) begin
            drive(t_store, 1'b0, make_instr(op_store, 3'(k), 7'($urandom),
                  5'($urandom)), 1'($urandom), '1, '1);
        end
        for (int k = 0; k < 9; k++) begin
            drive(t_fetch_stall, 1'b0, rand_instr(all_ops[k]), 1'($urandom), 5'b01111, '1);
        end

        wait_drain(5);
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_mp4_control

`default_nettype wire

// ==== list.f ====
common/pipe_ctrl_pkg.sv
decode/arith_decoder.sv
decode/ctrl_decoder.sv
hdl/stage_load_ctrl.sv
hdl/mp4_control.sv
verification/tb_mp4_control.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_mp4_control
FILELIST  ?= list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > sim.log 2>&1; rc=$$?; cat sim.log; \
	test $$rc -eq 0 && ! grep -q "Checks failed" sim.log

clean:
	rm -rf obj_dir sim.log
